/* files.f */
+incdir+test
verilog/reg_pkg.sv
verilog/agen_pkg.sv
verilog/effective_addr.sv
verilog/stack_ptr_unit.sv
verilog/dep_check.sv
verilog/scoreboard_gen.sv
verilog/agen_stage1.sv
verilog/agen_top.sv
test/agen_tb.sv

/* test/agen_model.svh */
`ifndef AGEN_MODEL_SVH
`define AGEN_MODEL_SVH

localparam int IN_W = $bits(agen_in_t);

logic [31:0] lcg_state = 32'hdf3ecbeb;

function automatic logic [31:0] lcg_step();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// Upper halves of two steps because the low LCG bits repeat quickly
function automatic logic [31:0] next_rand();
   logic [31:0] s1;
   logic [31:0] s2;
   s1 = lcg_step();
   s2 = lcg_step();
   return {s1[31:16], s2[31:16]};
endfunction

// About one bit in eight set
function automatic logic [31:0] sparse_word();
   return next_rand() & next_rand() & next_rand();
endfunction

function automatic sb_set_t rand_sb();
   logic [63:0] w;
   sb_set_t s;
   w = {sparse_word(), sparse_word()};
   s = w[39:0];
   return s;
endfunction

function automatic agen_in_t rand_input();
   logic [IN_W+31:0] raw;
   agen_in_t d;
   logic [31:0] r;
   for (int i = 0; i < (IN_W + 31) / 32; i++) begin
      raw[32*i +: 32] = next_rand();
   end
   d = raw[IN_W-1:0];
   r = next_rand();
   d.v = (r[31:29] != 3'b000);
   // Events kept rare so the other MM frame cases show up
   d.nmi = (r[28:26] == 3'b000);
   d.gp  = (r[25:23] == 3'b000);
   d.pf  = (r[22:20] == 3'b000);
   return d;
endfunction

// Lane bits of one GPR at a given size
function automatic gpr_sb_t lane_bits(reg_id_t id, op_size_t size);
   gpr_sb_t g;
   logic [2:0] l;
   if (size == 2'b00) begin
      l = 3'b001;
   end else if (size == 2'b01) begin
      l = 3'b011;
   end else begin
      l = 3'b111;
   end
   g = '0;
   g[3*id +: 3] = l;
   return g;
endfunction

function automatic logic [7:0] onehot_reg(reg_id_t id);
   logic [7:0] b;
   b = '0;
   b[id] = 1'b1;
   return b;
endfunction

function automatic logic find_hazard(agen_in_t d, sb_set_t s0, sb_set_t s1, sb_set_t s2,
                                     logic v0, logic v1, logic v2);
   sb_set_t need;
   logic hit;
   need = '0;
   if (d.sr1_needed) need.gpr = need.gpr | lane_bits(d.sr1, d.sr1_size);
   if (d.ctrl.sr2_needed) need.gpr = need.gpr | lane_bits(d.sr2, d.sr2_size);
   // SR3 of CMPXCHG is read at the SR2 size
   if (d.ctrl.is_cmpxchg) need.gpr = need.gpr | lane_bits(d.sr3, d.sr2_size);
   if (d.sib_en) need.gpr = need.gpr | lane_bits(d.sib_i, 2'b10);
   if (d.seg1_needed) need.seg = need.seg | onehot_reg(d.seg1);
   if (d.ctrl.seg2_needed) need.seg = need.seg | onehot_reg(d.seg2);
   if (d.mm1_needed) need.mm = need.mm | onehot_reg(d.sr1);
   if (d.ctrl.mm2_needed) need.mm = need.mm | onehot_reg(d.sr2);
   hit = (v0 && (|(need & s0))) || (v1 && (|(need & s1))) || (v2 && (|(need & s2)));
   return d.v && hit;
endfunction

function automatic sb_set_t reserved_sb(agen_in_t d, reg_id_t drid1);
   sb_set_t s;
   s = '0;
   if (d.ld_gpr1) s.gpr = s.gpr | lane_bits(drid1, d.dr1_size);
   if (d.ctrl.ld_gpr2) s.gpr = s.gpr | lane_bits(d.sr2, d.dr2_size);
   if (d.ctrl.ld_gpr3) s.gpr = s.gpr | lane_bits(d.ctrl.dr3, 2'b10);
   if (d.ctrl.ld_seg) s.seg = s.seg | onehot_reg(d.seg1);
   if (d.ctrl.ld_cs) s.seg = s.seg | onehot_reg(3'd1);
   if (d.ld_mm) s.mm = onehot_reg(drid1);
   if (!d.v) s = '0;
   return s;
endfunction

function automatic logic [3:0] pop_bytes(op_size_t size);
   if (size == 2'b11) return 4'd8;
   if (size == 2'b10) return 4'd4;
   return 4'd2;
endfunction

function automatic logic [31:0] next_sp(agen_in_t d, logic [31:0] temp_sp,
                                        logic [3:0] prev_pop);
   logic [31:0] base;
   base = d.ctrl.sp_use_temp ? temp_sp : d.sr2_data;
   if (!d.ctrl.sp_push) return base;
   if (d.ctrl.sp_add_pop) return base + prev_pop;
   return base - pop_bytes(d.mem_size);
endfunction

function automatic agen_out_t expected_out(agen_in_t d, logic [31:0] temp_sp,
                                           logic [3:0] prev_pop);
   agen_out_t r;
   logic ev;
   logic [15:0] seg;
   r = '0;
   ev = d.nmi | d.gp | d.pf;
   r.v = d.v;
   if (d.ctrl.next_eip_sel) r.neip = d.offset48[31:0];
   else if (d.ctrl.jmp_rel) r.neip = d.eip + d.offset48[31:0];
   else r.neip = d.eip;
   r.ncs = d.ctrl.next_cs_sel ? d.offset48[47:32] : d.cs;
   case (d.ctrl.a_sel)
      2'd0: r.a = d.sr1_data;
      2'd1: r.a = {16'h0, d.seg1_data};
      2'd2: r.a = {16'h0, d.seg2_data};
      default: r.a = {16'h0, d.cs};
   endcase
   r.b = d.ctrl.b_sel ? d.imm32 : d.sr2_data;
   if (ev || (d.ctrl.is_far_call && d.mem_size == 2'b11)) begin
      r.mm_a.raw = {16'h0, d.cs, d.eip};
   end else if (d.ctrl.is_far_call && d.mem_size == 2'b10) begin
      r.mm_a.raw = {d.mm1_data[63:32], d.cs, d.eip[15:0]};
   end else if (d.ctrl.is_far_call || d.ctrl.jmp_stall) begin
      r.mm_a.raw = {d.mm1_data[63:32], d.eip};
   end else begin
      r.mm_a.raw = d.mm1_data;
   end
   r.mm_b = d.mm2_data;
   r.sp_xchg = d.ctrl.is_cmpxchg ? d.sr3_data : next_sp(d, temp_sp, prev_pop);
   r.base_disp = (d.base_en ? d.sr1_data : 32'h0) + (d.disp_en ? d.disp32 : 32'h0);
   r.sib_si = d.sib_en ? (d.sib_i_data << d.sib_scale) : 32'h0;
   seg = d.seg_from_cs ? d.cs : d.seg1_data;
   r.sib_seg = {seg, 16'h0} + r.sib_si;
   if (d.gp) r.int_addr = IDT_GP_VEC;
   else if (d.pf) r.int_addr = IDT_PF_VEC;
   else r.int_addr = IDT_NMI_VEC;
   r.drid1 = d.ctrl.drid1_sel ? d.sr2 : d.sr1;
   r.drid2 = d.sr2;
   r.exc_v = d.v & ev;
   r.sb = reserved_sb(d, r.drid1);
   return r;
endfunction

`endif

/* test/agen_tb.sv */
`default_nettype none

module agen_tb;

   import reg_pkg::*;
   import agen_pkg::*;

   localparam int NUM_UOPS       = 2000;
   localparam int TIMEOUT_CYCLES = NUM_UOPS * 3 + 20;

   logic      CLK;
   logic      rst_n;
   agen_in_t  in;
   sb_set_t   ag2_sb;
   sb_set_t   me_sb;
   sb_set_t   ex_sb;
   logic      ag2_v;
   logic      me_v;
   logic      ex_v;
   logic      hold;
   agen_out_t out;
   logic      stall;
   logic      jmp_stall;

   `include "agen_model.svh"

   // Expected state of the output register and the stack unit
   agen_out_t   exp_q;
   logic        exp_v;
   logic        q_known;
   logic [31:0] sh_sp;
   logic [3:0]  sh_pop;
   logic        exp_stall;

   agen_in_t cur;
   int       done_cnt;
   int       tries;
   logic     take_new;
   int       cycles = 0;

   agen_top DUT (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .in        (in),
      .ag2_sb    (ag2_sb),
      .me_sb     (me_sb),
      .ex_sb     (ex_sb),
      .ag2_v     (ag2_v),
      .me_v      (me_v),
      .ex_v      (ex_v),
      .hold      (hold),
      .out       (out),
      .stall     (stall),
      .jmp_stall (jmp_stall)
   );

   always #20 CLK = ~CLK;

   always @(posedge CLK) begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT_CYCLES) begin
         $display("Timeout: the stage stopped accepting micro-ops");
         $display("Result: FAILED");
         $fatal(1, "Run exceeded the cycle limit");
      end
   end

   task automatic check_out(input agen_out_t got, input agen_out_t exp);
      if (got !== exp) begin
         $display("[ERROR] out: got %h expected %h", got, exp);
         $display("Result: FAILED");
         $fatal(1, "Output register mismatch");
      end
   endtask

   task automatic check_sb(input string name, input sb_set_t got, input sb_set_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got %h expected %h", name, got, exp);
         $display("Result: FAILED");
         $fatal(1, "Scoreboard mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got %h expected %h", name, got, exp);
         $display("Result: FAILED");
         $fatal(1, "Control bit mismatch");
      end
   endtask

   // Register contents are unknown until the first unstalled cycle
   task automatic verify_out_reg();
      agen_out_t want;
      check_bit("out.v", out.v, exp_v);
      if (q_known) begin
         want   = exp_q;
         want.v = exp_v;
         check_sb("out.sb", out.sb, exp_q.sb);
         check_out(out, want);
      end
   endtask

   // Random scoreboards of the later stages and AG2 back-pressure
   // A quiet cycle lets a stuck micro-op through
   task automatic drive_side(input logic quiet);
      logic [31:0] r;
      r      = next_rand();
      ag2_sb = rand_sb();
      me_sb  = rand_sb();
      ex_sb  = rand_sb();
      if (quiet) begin
         ag2_v = 1'b0;
         me_v  = 1'b0;
         ex_v  = 1'b0;
         hold  = 1'b0;
      end else begin
         ag2_v = r[31];
         me_v  = r[30];
         ex_v  = r[29];
         hold  = (r[28:26] == 3'b000);
      end
   endtask

   task automatic step_model();
      agen_out_t res;
      logic hz;
      logic exp_jmp;
      res       = expected_out(cur, sh_sp, sh_pop);
      hz        = find_hazard(cur, ag2_sb, me_sb, ex_sb, ag2_v, me_v, ex_v);
      exp_stall = hold | hz;
      exp_jmp   = cur.v & (cur.ctrl.jmp_stall | cur.ctrl.is_near_ret | cur.ctrl.is_far_ret);
      check_bit("stall", stall, exp_stall);
      check_bit("jmp_stall", jmp_stall, exp_jmp);
      if (!hold) begin
         exp_v = cur.v & ~hz;
      end
      if (!exp_stall) begin
         exp_q   = res;
         q_known = 1'b1;
      end
      // Shadow SP moves only on an accepted micro-op
      if (cur.v && !exp_stall) begin
         sh_sp  = next_sp(cur, sh_sp, sh_pop);
         sh_pop = pop_bytes(cur.mem_size);
      end
   endtask

   initial begin
      CLK      = 1'b0;
      rst_n    = 1'b0;
      in       = '0;
      ag2_sb   = '0;
      me_sb    = '0;
      ex_sb    = '0;
      ag2_v    = 1'b0;
      me_v     = 1'b0;
      ex_v     = 1'b0;
      hold     = 1'b0;
      exp_q    = '0;
      exp_v    = 1'b0;
      q_known  = 1'b0;
      sh_sp    = 32'h0;
      sh_pop   = 4'h0;
      done_cnt = 0;
      tries    = 0;
      take_new = 1'b1;

      repeat (10) @(negedge CLK);
      check_bit("out.v", out.v, 1'b0);
      check_bit("stall", stall, 1'b0);
      rst_n = 1'b1;

      while (done_cnt < NUM_UOPS) begin
         @(negedge CLK);
         verify_out_reg();
         if (take_new) begin
            cur   = rand_input();
            tries = 0;
         end else begin
            tries = tries + 1;
         end
         in = cur;
         drive_side(tries >= 2);
         #1;
         step_model();
         take_new = !cur.v || !exp_stall;
         if (take_new) begin
            done_cnt = done_cnt + 1;
         end
      end

      @(negedge CLK);
      verify_out_reg();
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/agen_pkg.sv */
`default_nettype none

package agen_pkg;

   // IDT entry addresses for the events handled in this stage
   localparam logic [31:0] IDT_NMI_VEC = 32'h0000_0010;
   localparam logic [31:0] IDT_GP_VEC  = 32'h0000_0068;
   localparam logic [31:0] IDT_PF_VEC  = 32'h0000_0070;

   // Control-store bits used by AG1
   typedef struct packed {
      logic             next_eip_sel;
      logic             jmp_rel;
      logic             next_cs_sel;
      logic [1:0]       a_sel;
      logic             b_sel;
      logic             is_far_call;
      logic             jmp_stall;
      logic             is_near_ret;
      logic             is_far_ret;
      logic             sp_push;
      logic             sp_add_pop;
      logic             sp_use_temp;
      logic             is_cmpxchg;
      logic             sr2_needed;
      logic             seg2_needed;
      logic             mm2_needed;
      logic             drid1_sel;
      logic             ld_gpr2;
      logic             ld_gpr3;
      logic             ld_seg;
      logic             ld_cs;
      reg_pkg::reg_id_t dr3;
   } uop_ctrl_t;

   // MM word, either raw data or a pushed far return frame
   typedef union packed {
      logic [63:0] raw;
      struct packed {
         logic [15:0] pad16;
         logic [15:0] sel;
         logic [31:0] ret_eip;
      } far_frame;
   } mm_word_u;

   typedef struct packed {
      logic              v;
      uop_ctrl_t         ctrl;
      logic [31:0]       eip;
      logic [15:0]       cs;
      logic [47:0]       offset48;
      logic [31:0]       imm32;
      logic [31:0]       disp32;
      reg_pkg::reg_id_t  sr1;
      reg_pkg::reg_id_t  sr2;
      reg_pkg::reg_id_t  sr3;
      reg_pkg::reg_id_t  sib_i;
      reg_pkg::reg_id_t  seg1;
      reg_pkg::reg_id_t  seg2;
      reg_pkg::op_size_t sr1_size;
      reg_pkg::op_size_t sr2_size;
      reg_pkg::op_size_t dr1_size;
      reg_pkg::op_size_t dr2_size;
      reg_pkg::op_size_t mem_size;
      logic              sr1_needed;
      logic              seg1_needed;
      logic              mm1_needed;
      logic              base_en;
      logic              disp_en;
      logic              sib_en;
      logic              seg_from_cs;
      logic              ld_gpr1;
      logic              ld_mm;
      logic [1:0]        sib_scale;
      logic [31:0]       sr1_data;
      logic [31:0]       sr2_data;
      logic [31:0]       sr3_data;
      logic [31:0]       sib_i_data;
      logic [15:0]       seg1_data;
      logic [15:0]       seg2_data;
      logic [63:0]       mm1_data;
      logic [63:0]       mm2_data;
      logic              nmi;
      logic              gp;
      logic              pf;
   } agen_in_t;

   typedef struct packed {
      logic             v;
      logic [31:0]      neip;
      logic [15:0]      ncs;
      logic [31:0]      a;
      logic [31:0]      b;
      mm_word_u         mm_a;
      logic [63:0]      mm_b;
      logic [31:0]      sp_xchg;
      logic [31:0]      base_disp;
      logic [31:0]      sib_seg;
      logic [31:0]      sib_si;
      logic [31:0]      int_addr;
      reg_pkg::reg_id_t drid1;
      reg_pkg::reg_id_t drid2;
      logic             exc_v;
      reg_pkg::sb_set_t sb;
   } agen_out_t;

endpackage

`default_nettype wire

/* verilog/agen_stage1.sv */
`default_nettype none

module agen_stage1 (
   input  wire logic               CLK,
   input  wire logic               rst_n,
   input  wire agen_pkg::agen_in_t d,
   input  wire reg_pkg::sb_set_t   ag2_sb,
   input  wire reg_pkg::sb_set_t   me_sb,
   input  wire reg_pkg::sb_set_t   ex_sb,
   input  wire logic               ag2_v,
   input  wire logic               me_v,
   input  wire logic               ex_v,
   input  wire logic               hold,
   output agen_pkg::agen_out_t     q,
   output logic                    stall,
   output logic                    jmp_stall
);

   import reg_pkg::*;
   import agen_pkg::*;

   agen_out_t   res;
   agen_out_t   out_q;
   logic        out_v;
   logic        hazard;
   logic        accept;
   logic        any_event;
   logic [31:0] rel_off;
   logic [31:0] sp_next;
   logic [31:0] base_disp;
   logic [31:0] sib_si;
   logic [31:0] sib_seg;
   sb_set_t     sb;

   effective_addr u_effective_addr (
      .d         (d),
      .base_disp (base_disp),
      .sib_si    (sib_si),
      .sib_seg   (sib_seg)
   );

   stack_ptr_unit u_stack_ptr_unit (
      .CLK     (CLK),
      .rst_n   (rst_n),
      .accept  (accept),
      .d       (d),
      .sp_next (sp_next)
   );

   dep_check u_dep_check (
      .d      (d),
      .ag2_sb (ag2_sb),
      .me_sb  (me_sb),
      .ex_sb  (ex_sb),
      .ag2_v  (ag2_v),
      .me_v   (me_v),
      .ex_v   (ex_v),
      .hazard (hazard)
   );

   scoreboard_gen u_scoreboard_gen (
      .d     (d),
      .drid1 (res.drid1),
      .drid2 (res.drid2),
      .sb    (sb)
   );

   assign stall     = hold | hazard;
   assign accept    = d.v & ~stall;
   assign any_event = d.nmi | d.gp | d.pf;
   assign rel_off   = d.ctrl.jmp_rel ? d.offset48[31:0] : 32'h0;

   // Branches and returns hold fetch until the target is known
   assign jmp_stall = d.v & (d.ctrl.jmp_stall | d.ctrl.is_near_ret | d.ctrl.is_far_ret);

   always_comb begin
      res.v    = d.v;
      res.neip = d.ctrl.next_eip_sel ? d.offset48[31:0] : d.eip + rel_off;
      res.ncs  = d.ctrl.next_cs_sel ? d.offset48[47:32] : d.cs;

      case (d.ctrl.a_sel)
         2'd0:    res.a = d.sr1_data;
         2'd1:    res.a = {16'h0, d.seg1_data};
         2'd2:    res.a = {16'h0, d.seg2_data};
         default: res.a = {16'h0, d.cs};
      endcase
      res.b = d.ctrl.b_sel ? d.imm32 : d.sr2_data;

      // Return frame pushed by far calls and events
      if (any_event || (d.ctrl.is_far_call && d.mem_size == SZ_QWORD)) begin
         res.mm_a.far_frame.pad16   = 16'h0;
         res.mm_a.far_frame.sel     = d.cs;
         res.mm_a.far_frame.ret_eip = d.eip;
      end else if (d.ctrl.is_far_call && d.mem_size == SZ_DWORD) begin
         res.mm_a.raw = {d.mm1_data[63:32], d.cs, d.eip[15:0]};
      end else if (d.ctrl.is_far_call || d.ctrl.jmp_stall) begin
         res.mm_a.raw = {d.mm1_data[63:32], d.eip};
      end else begin
         res.mm_a.raw = d.mm1_data;
      end
      res.mm_b = d.mm2_data;

      res.sp_xchg   = d.ctrl.is_cmpxchg ? d.sr3_data : sp_next;
      res.base_disp = base_disp;
      res.sib_seg   = sib_seg;
      res.sib_si    = sib_si;

      // GP wins over PF, PF over NMI
      if (d.gp) begin
         res.int_addr = IDT_GP_VEC;
      end else if (d.pf) begin
         res.int_addr = IDT_PF_VEC;
      end else begin
         res.int_addr = IDT_NMI_VEC;
      end

      res.drid1 = d.ctrl.drid1_sel ? d.sr2 : d.sr1;
      res.drid2 = d.sr2;
      res.exc_v = d.v & any_event;
      res.sb    = sb;
   end

   // A hazard drops the valid, a hold freezes everything
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         out_v <= 1'b0;
      end else if (!hold) begin
         out_v <= d.v & ~hazard;
      end
   end

   always_ff @(posedge CLK) begin
      if (!stall) begin
         out_q <= res;
      end
   end

   always_comb begin
      q   = out_q;
      q.v = out_v;
   end

endmodule

`default_nettype wire

/* verilog/agen_top.sv */
`default_nettype none

module agen_top (
   input  wire logic               CLK,
   input  wire logic               rst_n,
   input  wire agen_pkg::agen_in_t in,
   input  wire reg_pkg::sb_set_t   ag2_sb,
   input  wire reg_pkg::sb_set_t   me_sb,
   input  wire reg_pkg::sb_set_t   ex_sb,
   input  wire logic               ag2_v,
   input  wire logic               me_v,
   input  wire logic               ex_v,
   input  wire logic               hold,
   output agen_pkg::agen_out_t     out,
   output logic                    stall,
   output logic                    jmp_stall
);

   // First address-generation stage
   agen_stage1 u_agen_stage1 (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .d         (in),
      .ag2_sb    (ag2_sb),
      .me_sb     (me_sb),
      .ex_sb     (ex_sb),
      .ag2_v     (ag2_v),
      .me_v      (me_v),
      .ex_v      (ex_v),
      .hold      (hold),
      .q         (out),
      .stall     (stall),
      .jmp_stall (jmp_stall)
   );

endmodule

`default_nettype wire

/* verilog/dep_check.sv */
`default_nettype none

module dep_check (
   input  wire agen_pkg::agen_in_t d,
   input  wire reg_pkg::sb_set_t   ag2_sb,
   input  wire reg_pkg::sb_set_t   me_sb,
   input  wire reg_pkg::sb_set_t   ex_sb,
   input  wire logic               ag2_v,
   input  wire logic               me_v,
   input  wire logic               ex_v,
   output logic                    hazard
);

   import reg_pkg::*;

   sb_set_t need;
   logic    hit_ag2;
   logic    hit_me;
   logic    hit_ex;

   // Overlap of the needed sources with one stage's reservations
   function automatic logic sb_hit(sb_set_t src, sb_set_t sb);
      return (|(src.gpr & sb.gpr)) | (|(src.seg & sb.seg)) | (|(src.mm & sb.mm));
   endfunction

   // Collect every lane and register bit this micro-op reads
   always_comb begin
      need = '0;
      if (d.sr1_needed) begin
         need.gpr = need.gpr | gpr_lanes(d.sr1, d.sr1_size);
      end
      if (d.ctrl.sr2_needed) begin
         need.gpr = need.gpr | gpr_lanes(d.sr2, d.sr2_size);
      end
      // CMPXCHG compares against SR3 at the accumulator size
      if (d.ctrl.is_cmpxchg) begin
         need.gpr = need.gpr | gpr_lanes(d.sr3, d.sr2_size);
      end
      if (d.sib_en) begin
         need.gpr = need.gpr | gpr_lanes(d.sib_i, SZ_DWORD);
      end
      if (d.seg1_needed) begin
         need.seg = need.seg | reg_bit(d.seg1);
      end
      if (d.ctrl.seg2_needed) begin
         need.seg = need.seg | reg_bit(d.seg2);
      end
      if (d.mm1_needed) begin
         need.mm = need.mm | reg_bit(d.sr1);
      end
      if (d.ctrl.mm2_needed) begin
         need.mm = need.mm | reg_bit(d.sr2);
      end
   end

   assign hit_ag2 = ag2_v & sb_hit(need, ag2_sb);
   assign hit_me  = me_v & sb_hit(need, me_sb);
   assign hit_ex  = ex_v & sb_hit(need, ex_sb);

   // An empty slot never stalls
   assign hazard = d.v & (hit_ag2 | hit_me | hit_ex);

endmodule

`default_nettype wire

/* verilog/effective_addr.sv */
`default_nettype none

module effective_addr (
   input  wire agen_pkg::agen_in_t d,
   output logic [31:0]             base_disp,
   output logic [31:0]             sib_si,
   output logic [31:0]             sib_seg
);

   logic [31:0] base_val;
   logic [31:0] disp_val;
   logic [31:0] idx_shifted;
   logic [15:0] seg_sel;

   // Base register and displacement, each optional
   always_comb begin
      base_val = d.base_en ? d.sr1_data : 32'h0;
      disp_val = d.disp_en ? d.disp32 : 32'h0;
   end

   assign base_disp = base_val + disp_val;

   // Scaled index, scale is a power of two from 1 to 8
   assign idx_shifted = d.sib_i_data << d.sib_scale;

   always_comb begin
      if (d.sib_en) begin
         sib_si = idx_shifted;
      end else begin
         sib_si = 32'h0;
      end
   end

   // Segment base comes from SEG1 or from CS for code-relative forms
   assign seg_sel = d.seg_from_cs ? d.cs : d.seg1_data;

   // Segment sits in the upper half of the partial address
   assign sib_seg = {seg_sel, 16'h0000} + sib_si;

endmodule

`default_nettype wire

/* verilog/reg_pkg.sv */
`default_nettype none

package reg_pkg;

   localparam int NUM_REGS  = 8;
   localparam int GPR_LANES = 3;

   typedef logic [2:0] reg_id_t;
   typedef logic [1:0] op_size_t;
   typedef logic [NUM_REGS*GPR_LANES-1:0] gpr_sb_t;
   typedef logic [NUM_REGS-1:0] seg_sb_t;
   typedef logic [NUM_REGS-1:0] mm_sb_t;

   // Operand size encodings
   localparam op_size_t SZ_BYTE  = 2'b00;
   localparam op_size_t SZ_WORD  = 2'b01;
   localparam op_size_t SZ_DWORD = 2'b10;
   localparam op_size_t SZ_QWORD = 2'b11;

   // Lane groups of one GPR entry: low byte, second byte, upper half
   localparam logic [2:0] LANES_BYTE  = 3'b001;
   localparam logic [2:0] LANES_WORD  = 3'b011;
   localparam logic [2:0] LANES_DWORD = 3'b111;

   // Segment register number of CS
   localparam reg_id_t SEG_CS = 3'd1;

   typedef struct packed {
      gpr_sb_t gpr;
      seg_sb_t seg;
      mm_sb_t  mm;
   } sb_set_t;

   function automatic logic [2:0] lane_mask(op_size_t size);
      case (size)
         SZ_BYTE: return LANES_BYTE;
         SZ_WORD: return LANES_WORD;
         default: return LANES_DWORD;
      endcase
   endfunction

   // Lanes of register id at the given size, placed at bits 3n..3n+2
   function automatic gpr_sb_t gpr_lanes(reg_id_t id, op_size_t size);
      return gpr_sb_t'(lane_mask(size)) << (GPR_LANES * id);
   endfunction

   function automatic logic [NUM_REGS-1:0] reg_bit(reg_id_t id);
      return {{(NUM_REGS-1){1'b0}}, 1'b1} << id;
   endfunction

endpackage

`default_nettype wire

/* verilog/scoreboard_gen.sv */
`default_nettype none

module scoreboard_gen (
   input  wire agen_pkg::agen_in_t d,
   input  wire reg_pkg::reg_id_t   drid1,
   input  wire reg_pkg::reg_id_t   drid2,
   output reg_pkg::sb_set_t        sb
);

   import reg_pkg::*;

   gpr_sb_t gpr_res;
   seg_sb_t seg_res;
   mm_sb_t  mm_res;

   // GPR lanes written back by this micro-op
   always_comb begin
      gpr_res = '0;
      if (d.ld_gpr1) begin
         gpr_res = gpr_res | gpr_lanes(drid1, d.dr1_size);
      end
      if (d.ctrl.ld_gpr2) begin
         gpr_res = gpr_res | gpr_lanes(drid2, d.dr2_size);
      end
      // Third destination is always a full dword
      if (d.ctrl.ld_gpr3) begin
         gpr_res = gpr_res | gpr_lanes(d.ctrl.dr3, SZ_DWORD);
      end
   end

   always_comb begin
      seg_res = '0;
      if (d.ctrl.ld_seg) begin
         seg_res = seg_res | reg_bit(d.seg1);
      end
      // Far transfers reload CS
      if (d.ctrl.ld_cs) begin
         seg_res = seg_res | reg_bit(SEG_CS);
      end
   end

   assign mm_res = d.ld_mm ? reg_bit(drid1) : '0;

   always_comb begin
      if (d.v) begin
         sb.gpr = gpr_res;
         sb.seg = seg_res;
         sb.mm  = mm_res;
      end else begin
         sb = '0;
      end
   end

endmodule

`default_nettype wire

/* verilog/stack_ptr_unit.sv */
`default_nettype none

module stack_ptr_unit (
   input  wire logic               CLK,
   input  wire logic               rst_n,
   input  wire logic               accept,
   input  wire agen_pkg::agen_in_t d,
   output logic [31:0]             sp_next
);

   import reg_pkg::*;

   logic [31:0] temp_sp;
   logic [3:0]  prev_pop_size;
   logic [3:0]  pop_size;
   logic [31:0] step;
   logic [31:0] base;

   // Bytes moved per stack access; byte pushes still move a word
   always_comb begin
      case (d.mem_size)
         SZ_QWORD: pop_size = 4'd8;
         SZ_DWORD: pop_size = 4'd4;
         SZ_WORD:  pop_size = 4'd2;
         default:  pop_size = 4'd2;
      endcase
   end

   always_comb begin
      if (!d.ctrl.sp_push) begin
         step = 32'h0;
      end else if (d.ctrl.sp_add_pop) begin
         // Pop walks up by the size of the previous access
         step = {28'h0, prev_pop_size};
      end else begin
         step = -{28'h0, pop_size};
      end
   end

   // Multi-access sequences continue from the temporary SP
   assign base    = d.ctrl.sp_use_temp ? temp_sp : d.sr2_data;
   assign sp_next = base + step;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         temp_sp       <= 32'h0;
         prev_pop_size <= 4'h0;
      end else if (accept) begin
         temp_sp       <= sp_next;
         prev_pop_size <= pop_size;
      end
   end

endmodule

`default_nettype wire
